// ==== Makefile ====
TOP = tb_icache

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f icache_top.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== icache_top.f ====
+incdir+tests
verilog/icache_pkg.sv
verilog/way_ram.sv
verilog/lru_table.sv
verilog/fetch_path.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/tb_icache.sv

// ==== tests/tb_icache_cases.svh ====
`ifndef TB_ICACHE_CASES_SVH
`define TB_ICACHE_CASES_SVH

// one entry per fetch, applied in order
// addr, misaligned, expect_miss, idle cycles before the request
localparam int NUM_CASES = 18;

localparam case_t CASES [NUM_CASES] = '{
    '{32'h0000_1000, 1'b0, 1'b1, 4'd2},  // cold line, set 0
    '{32'h0000_1018, 1'b0, 1'b0, 4'd1},  // other word, same line
    '{32'h0000_1020, 1'b0, 1'b0, 4'd0},  // back-to-back hits
    '{32'h0000_1030, 1'b0, 1'b0, 4'd0},
    '{32'h0000_1038, 1'b0, 1'b0, 4'd0},
    '{32'h0000_1008, 1'b0, 1'b0, 4'd0},
    '{32'h0000_2140, 1'b0, 1'b1, 4'd2},  // A in set 5
    '{32'h0000_3148, 1'b0, 1'b1, 4'd1},  // B in set 5
    '{32'h0000_2150, 1'b0, 1'b0, 4'd1},  // A again, B becomes LRU
    '{32'h0000_4140, 1'b0, 1'b1, 4'd0},  // C evicts B
    '{32'h0000_2178, 1'b0, 1'b0, 4'd0},  // A taken during C refill
    '{32'h0000_3140, 1'b0, 1'b1, 4'd1},  // B was evicted
    '{32'h0000_1002, 1'b1, 1'b0, 4'd1},  // misaligned on a cached line
    '{32'h0000_7001, 1'b1, 1'b0, 4'd0},  // misaligned, line not cached
    '{32'h0000_8000, 1'b0, 1'b1, 4'd2},  // set 0, second way
    '{32'h0000_8028, 1'b0, 1'b0, 4'd0},  // same line, accepted in refill
    '{32'h0000_1010, 1'b0, 1'b0, 4'd0},  // first line still in set 0
    '{32'h0000_5003, 1'b1, 1'b0, 4'd3}
};

`endif

// ==== tests/tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache;

    localparam int          CLK_PERIOD    = 100;
    localparam int          DRIVE_DLY     = 10;
    localparam int          SEED          = 96;
    localparam int          MAX_MEM_DELAY = 5;
    localparam int          WORST_CYCLES  = 16;  // gap, lookup, memory wait and refill
    localparam int          MARGIN_CYCLES = 40;
    localparam logic [31:0] MEM_KEY       = 32'hA5C3_0F96;

    typedef struct packed {
        logic [31:0] addr;
        logic        misaligned;
        logic        expect_miss;
        logic [3:0]  gap;
    } case_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        misaligned;
        logic        expect_miss;
        logic [31:0] accept_cyc;
    } pending_t;

    `include "tb_icache_cases.svh"

    localparam int WATCHDOG_CYCLES = NUM_CASES * WORST_CYCLES + MARGIN_CYCLES;

    logic                    clk;
    logic                    rstn;
    logic                    i_req_valid;
    icache_pkg::fetch_req_t  i_req;
    logic                    o_req_ready;
    logic                    o_resp_valid;
    icache_pkg::fetch_resp_t o_resp;
    logic                    o_mem_valid;
    icache_pkg::mem_req_t    o_mem_req;
    logic                    i_mem_ready;
    icache_pkg::line_t       i_mem_line;

    pending_t    exp_q[$];    // accepted but not yet answered
    bit          mem_seen;    // head of exp_q went to memory
    int unsigned fire_cyc;    // cycle of the last line handshake
    int unsigned cyc;

    icache_top u_icache_top (
        .clk         (clk),
        .rstn        (rstn),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .o_resp_valid(o_resp_valid),
        .o_resp      (o_resp),
        .o_mem_valid (o_mem_valid),
        .o_mem_req   (o_mem_req),
        .i_mem_ready (i_mem_ready),
        .i_mem_line  (i_mem_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic fail_run(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // every 32-bit word holds its own byte address xor the key
    function automatic logic [63:0] expected_slice(input logic [31:0] addr);
        logic [31:0] lo_addr;
        lo_addr = {addr[31:3], 3'b000};
        return {(lo_addr + 32'd4) ^ MEM_KEY, lo_addr ^ MEM_KEY};
    endfunction

    function automatic icache_pkg::line_t line_from_memory(input logic [31:0] base);
        icache_pkg::line_t line;
        for (int i = 0; i < 16; i++) begin
            line[i*32 +: 32] = (base + 32'(4 * i)) ^ MEM_KEY;
        end
        return line;
    endfunction

    task automatic check_response();
        pending_t exp;
        assert (exp_q.size() > 0) else
            fail_run("response with no request outstanding");
        exp = exp_q.pop_front();
        assert (o_resp.pc == exp.addr) else
            fail_run($sformatf("pc %h, expected %h", o_resp.pc, exp.addr));
        assert (o_resp.exc == exp.misaligned) else
            fail_run($sformatf("exception flag %b for pc %h", o_resp.exc, exp.addr));
        if (!exp.misaligned) begin
            assert (o_resp.data == expected_slice(exp.addr)) else
                fail_run($sformatf("data %h for pc %h, expected %h",
                                   o_resp.data, exp.addr, expected_slice(exp.addr)));
        end
        if (exp.expect_miss) begin
            assert (mem_seen && cyc == fire_cyc + 1) else
                fail_run($sformatf("pc %h not answered the cycle after its line read",
                                   exp.addr));
        end else begin
            assert (cyc == exp.accept_cyc + 32'd1) else
                fail_run($sformatf("pc %h not answered the cycle after acceptance",
                                   exp.addr));
        end
        mem_seen = 1'b0;
    endtask

    // outputs sampled mid-cycle away from both edges
    always @(negedge clk) begin
        if (rstn) begin
            if (o_mem_valid) begin
                assert (exp_q.size() > 0 && exp_q[0].expect_miss) else
                    fail_run("line read for a request that should not miss");
                assert (o_mem_req.addr == {exp_q[0].addr[31:6], 6'd0}) else
                    fail_run($sformatf("line address %h for pc %h",
                                       o_mem_req.addr, exp_q[0].addr));
                assert (!o_req_ready) else
                    fail_run("request port ready while a miss waits for memory");
                mem_seen = 1'b1;
                if (i_mem_ready) begin
                    fire_cyc = cyc;  // line taken at the coming edge
                end
            end
            if (o_resp_valid) begin
                assert (o_req_ready) else
                    fail_run("request port not ready in a response cycle");
                check_response();
            end
        end
    end

    task automatic issue_request(input case_t c);
        bit       accepted;
        pending_t entry;
        accepted    = 1'b0;
        i_req_valid = 1'b1;
        i_req.addr  = c.addr;
        while (!accepted) begin
            @(negedge clk);
            if (o_req_ready) begin  // taken at the coming edge
                accepted          = 1'b1;
                entry.addr        = c.addr;
                entry.misaligned  = c.misaligned;
                entry.expect_miss = c.expect_miss;
                entry.accept_cyc  = cyc;
                exp_q.push_back(entry);
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        i_req_valid = 1'b0;
    endtask

    // memory answers a line read after 0 to MAX_MEM_DELAY cycles
    initial begin : memory_model
        int wait_cycles;
        i_mem_ready = 1'b0;
        i_mem_line  = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (rstn && o_mem_valid) begin
                wait_cycles = $urandom % (MAX_MEM_DELAY + 1);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                i_mem_line  = line_from_memory(o_mem_req.addr);
                i_mem_ready = 1'b1;
                @(posedge clk);  // handshake edge
                #DRIVE_DLY;
                i_mem_ready = 1'b0;
                i_mem_line  = '0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired: the cache stopped answering fetches");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : main
        clk         = 1'b0;
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        mem_seen    = 1'b0;
        fire_cyc    = 0;
        void'($urandom(SEED));

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;

        @(negedge clk);
        assert (o_req_ready && !o_resp_valid && !o_mem_valid) else
            fail_run("outputs not at their reset values");
        @(posedge clk);
        #DRIVE_DLY;

        for (int n = 0; n < NUM_CASES; n++) begin
            repeat (CASES[n].gap) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            issue_request(CASES[n]);
        end

        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // catch stray responses

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== verilog/fetch_path.sv ====
`timescale 1ns/10ps

module fetch_path (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  icache_pkg::fetch_req_t                        i_req,
    input  logic                                          i_buf_load,
    input  logic                                          i_mem_fire,
    input  icache_pkg::line_t                             i_mem_line,
    input  logic                                          i_from_refill,
    input  icache_pkg::tagv_t [icache_pkg::WAYS-1:0]      i_tagv,
    input  icache_pkg::line_t [icache_pkg::WAYS-1:0]      i_lines,
    output logic [icache_pkg::INDEX_W-1:0]                o_rd_index,
    output logic [icache_pkg::INDEX_W-1:0]                o_wr_index,
    output icache_pkg::tagv_t                             o_wr_tagv,
    output icache_pkg::line_t                             o_refill_line,
    output logic                                          o_hit,
    output icache_pkg::way_sel_t                          o_hit_way,
    output logic                                          o_misaligned,
    output icache_pkg::fetch_resp_t                       o_resp,
    output icache_pkg::mem_req_t                          o_mem_req
);

    icache_pkg::fetch_req_t        req_buf;   // address under lookup
    icache_pkg::line_t             ret_buf;   // line from memory
    icache_pkg::line_t             way_line;
    icache_pkg::line_t             src_line;
    logic [icache_pkg::TAG_W-1:0]  req_tag;
    logic [icache_pkg::INDEX_W-1:0] req_index;
    icache_pkg::way_sel_t          hit_vec;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_buf <= '0;
        end else if (i_buf_load) begin
            req_buf <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_mem_fire) begin
            ret_buf <= i_mem_line;
        end
    end

    assign req_tag   = req_buf.addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign req_index = req_buf.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    // new set on accept, otherwise keep the arrays pointed at the buffered set
    assign o_rd_index = i_buf_load ? i_req.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W]
                                   : req_index;
    assign o_wr_index    = req_index;
    assign o_wr_tagv     = '{valid: 1'b1, tag: req_tag};
    assign o_refill_line = ret_buf;
    assign o_mem_req     = '{addr: {req_buf.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                                    {icache_pkg::OFFSET_W{1'b0}}}};

    assign o_misaligned = |req_buf.addr[1:0];  // fetches are word aligned

    // both ways compared at once
    always_comb begin
        hit_vec  = '0;
        way_line = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            hit_vec[w] = i_tagv[w].valid && (i_tagv[w].tag == req_tag);
            if (hit_vec[w]) begin
                way_line = way_line | i_lines[w];
            end
        end
    end

    assign o_hit     = |hit_vec;
    assign o_hit_way = hit_vec;

    assign src_line = i_from_refill ? ret_buf : way_line;

    // 64-bit slice picked by addr[5:3]
    assign o_resp = '{
        pc:   req_buf.addr,
        data: src_line[req_buf.addr[icache_pkg::OFFSET_W-1:3] * icache_pkg::FETCH_W
                       +: icache_pkg::FETCH_W],
        exc:  o_misaligned
    };

    // refill always takes the victim, so a line never sits in two ways
    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(hit_vec));

endmodule

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_req_valid,
    input  logic                 i_hit,
    input  icache_pkg::way_sel_t i_hit_way,
    input  logic                 i_misaligned,
    input  icache_pkg::way_sel_t i_victim,
    input  logic                 i_mem_ready,
    output logic                 o_req_ready,
    output logic                 o_buf_load,
    output logic                 o_from_refill,
    output logic                 o_resp_valid,
    output logic                 o_mem_valid,
    output icache_pkg::way_sel_t o_way_we,
    output logic                 o_lru_we,
    output icache_pkg::way_sel_t o_lru_way
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL
    } state_t;

    state_t state;
    state_t next_state;
    logic   lookup_done;  // answered without memory
    logic   accept;

    assign lookup_done = (state == S_LOOKUP) && (i_hit || i_misaligned);

    // only a pending miss blocks new requests
    assign o_req_ready = (state == S_IDLE) || (state == S_REFILL) || lookup_done;
    assign accept      = i_req_valid && o_req_ready;
    assign o_buf_load  = accept;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    next_state = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (!lookup_done) begin
                    next_state = S_MISS;
                end else if (!accept) begin
                    next_state = S_IDLE;
                end
            end
            S_MISS: begin
                if (i_mem_ready) begin  // line sampled on this edge
                    next_state = S_REFILL;
                end
            end
            S_REFILL: begin
                next_state = accept ? S_LOOKUP : S_IDLE;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    always_comb begin
        o_resp_valid  = lookup_done;
        o_mem_valid   = (state == S_MISS);
        o_from_refill = 1'b0;
        o_way_we      = '0;
        o_lru_we      = lookup_done && !i_misaligned;  // touch the hit way
        o_lru_way     = i_hit_way;
        if (state == S_REFILL) begin
            o_resp_valid  = 1'b1;
            o_from_refill = 1'b1;
            o_way_we      = i_victim;
            o_lru_we      = 1'b1;
            o_lru_way     = i_victim;
        end
    end

    // arrays change only right after a memory handshake, one way at a time
    a_way_write: assert property (@(posedge clk) disable iff (!rstn)
        (|o_way_we) |-> $onehot(o_way_we) && $past(o_mem_valid && i_mem_ready));

endmodule

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

    // address split, physical addresses only
    localparam int ADDR_W   = 32;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;                          // byte offset in a 64-byte line
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 20 bits
    localparam int SETS     = 1 << INDEX_W;

    localparam int LINE_W  = 8 << OFFSET_W;  // 512
    localparam int FETCH_W = 64;             // two instructions per fetch
    localparam int WAYS    = 2;

    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [FETCH_W-1:0] data;
        logic               exc;   // fetch address exception
    } fetch_resp_t;

    // whole-line read, low offset bits zero
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef logic [WAYS-1:0] way_sel_t;  // one-hot

endpackage

// ==== verilog/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_req_valid,
    input  icache_pkg::fetch_req_t  i_req,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output icache_pkg::fetch_resp_t o_resp,
    output logic                    o_mem_valid,
    output icache_pkg::mem_req_t    o_mem_req,
    input  logic                    i_mem_ready,
    input  icache_pkg::line_t       i_mem_line
);

    logic                                     hit;
    logic                                     misaligned;
    logic                                     buf_load;
    logic                                     from_refill;
    logic                                     lru_we;
    logic                                     mem_fire;
    icache_pkg::way_sel_t                     hit_way;
    icache_pkg::way_sel_t                     victim;
    icache_pkg::way_sel_t                     way_we;
    icache_pkg::way_sel_t                     lru_way;
    logic [icache_pkg::INDEX_W-1:0]           rd_index;
    logic [icache_pkg::INDEX_W-1:0]           wr_index;
    icache_pkg::tagv_t                        wr_tagv;
    icache_pkg::line_t                        refill_line;
    icache_pkg::tagv_t [icache_pkg::WAYS-1:0] tagv_rd;
    icache_pkg::line_t [icache_pkg::WAYS-1:0] line_rd;

    assign mem_fire = o_mem_valid && i_mem_ready;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_hit        (hit),
        .i_hit_way    (hit_way),
        .i_misaligned (misaligned),
        .i_victim     (victim),
        .i_mem_ready  (i_mem_ready),
        .o_req_ready  (o_req_ready),
        .o_buf_load   (buf_load),
        .o_from_refill(from_refill),
        .o_resp_valid (o_resp_valid),
        .o_mem_valid  (o_mem_valid),
        .o_way_we     (way_we),
        .o_lru_we     (lru_we),
        .o_lru_way    (lru_way)
    );

    fetch_path u_fetch_path (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_buf_load   (buf_load),
        .i_mem_fire   (mem_fire),
        .i_mem_line   (i_mem_line),
        .i_from_refill(from_refill),
        .i_tagv       (tagv_rd),
        .i_lines      (line_rd),
        .o_rd_index   (rd_index),
        .o_wr_index   (wr_index),
        .o_wr_tagv    (wr_tagv),
        .o_refill_line(refill_line),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_misaligned (misaligned),
        .o_resp       (o_resp),
        .o_mem_req    (o_mem_req)
    );

    lru_table u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .i_index   (wr_index),  // set of the buffered request
        .i_we      (lru_we),
        .i_used_way(lru_way),
        .o_victim  (victim)
    );

    // data and tag arrays per way
    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
        way_ram #(
            .payload_t   (icache_pkg::line_t),
            .CLEAR_ON_RST(1'b0)
        ) u_data (
            .clk       (clk),
            .rstn      (rstn),
            .i_rd_index(rd_index),
            .i_wr_index(wr_index),
            .i_we      (way_we[w]),
            .i_wdata   (refill_line),
            .o_rdata   (line_rd[w])
        );

        way_ram #(
            .payload_t   (icache_pkg::tagv_t),
            .CLEAR_ON_RST(1'b1)
        ) u_tagv (
            .clk       (clk),
            .rstn      (rstn),
            .i_rd_index(rd_index),
            .i_wr_index(wr_index),
            .i_we      (way_we[w]),
            .i_wdata   (wr_tagv),
            .o_rdata   (tagv_rd[w])
        );
    end

endmodule

// ==== verilog/lru_table.sv ====
`timescale 1ns/10ps

module lru_table (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [icache_pkg::INDEX_W-1:0] i_index,
    input  logic                           i_we,
    input  icache_pkg::way_sel_t           i_used_way,
    output icache_pkg::way_sel_t           o_victim
);

    // one bit per set, 1 means way 1 was touched last
    logic [icache_pkg::SETS-1:0] mru;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (i_we) begin
            mru[i_index] <= i_used_way[1];
        end
    end

    // evict the way not used most recently
    always_comb begin
        if (mru[i_index]) begin
            o_victim = 2'b01;
        end else begin
            o_victim = 2'b10;
        end
    end

endmodule

// ==== verilog/way_ram.sv ====
`timescale 1ns/10ps

module way_ram #(
    parameter type payload_t    = icache_pkg::line_t,
    parameter bit  CLEAR_ON_RST = 1'b0
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [icache_pkg::INDEX_W-1:0] i_rd_index,
    input  logic [icache_pkg::INDEX_W-1:0] i_wr_index,
    input  logic                           i_we,
    input  payload_t                       i_wdata,
    output payload_t                       o_rdata
);

    payload_t mem [icache_pkg::SETS];
    logic     bypass;

    // write-first when the same set is read and written in one cycle
    assign bypass = i_we && (i_wr_index == i_rd_index);

    if (CLEAR_ON_RST) begin : g_clear
        always_ff @(posedge clk) begin
            if (!rstn) begin
                for (int i = 0; i < icache_pkg::SETS; i++) begin
                    mem[i] <= '0;  // all valid bits start low
                end
                o_rdata <= '0;
            end else begin
                if (i_we) begin
                    mem[i_wr_index] <= i_wdata;
                end
                o_rdata <= bypass ? i_wdata : mem[i_rd_index];
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk) begin
            if (i_we) begin
                mem[i_wr_index] <= i_wdata;
            end
            o_rdata <= bypass ? i_wdata : mem[i_rd_index];
        end
    end

endmodule
